// ==== Makefile ====
SIM      := verilator
FLAGS    := --binary --timing --assert --timescale 1ns/100ps
TOP      := imuldiv_tb
FILELIST := filelist.f

OBJDIR   := obj_dir
BIN      := $(OBJDIR)/V$(TOP)
SOURCES  := $(shell grep -v '^+' $(FILELIST)) bench/imuldiv_ref.svh

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJDIR)

run: $(BIN)
	./$(BIN) | tee /dev/stderr | grep -x 'sim passed' > /dev/null

clean:
	rm -rf $(OBJDIR)

// ==== bench/imuldiv_ref.svh ====
//------------------------------------------------
// expected result of one mul/div request, from plain arithmetic
// included inside the testbench module after the package import
//------------------------------------------------

`ifndef IMULDIV_REF_SVH
`define IMULDIV_REF_SVH

// multiply gives the full product, divide gives {remainder, quotient}
function automatic logic [2*imuldiv_w-1:0] expected_result(input imuldiv_req_t r);
  logic                 sgn;
  logic                 a_neg;
  logic                 b_neg;
  logic [imuldiv_w-1:0] a_mag;
  logic [imuldiv_w-1:0] b_mag;
  logic [imuldiv_w-1:0] q_mag;
  logic [imuldiv_w-1:0] r_mag;
  logic [imuldiv_w-1:0] quot;
  logic [imuldiv_w-1:0] rem;

  sgn = (r.fn == fn_mul) || (r.fn == fn_div);

  // low 2W bits of a product of extended operands are exact
  if (r.fn == fn_mul) begin
    return {{imuldiv_w{r.a[imuldiv_w-1]}}, r.a} * {{imuldiv_w{r.b[imuldiv_w-1]}}, r.b};
  end
  if (r.fn == fn_mulu) begin
    return {{imuldiv_w{1'b0}}, r.a} * {{imuldiv_w{1'b0}}, r.b};
  end

  // divide on magnitudes, most-negative maps onto 2^(W-1)
  a_neg = sgn & r.a[imuldiv_w-1];
  b_neg = sgn & r.b[imuldiv_w-1];
  a_mag = a_neg ? -r.a : r.a;
  b_mag = b_neg ? -r.b : r.b;

  // divide by zero: all-ones quotient, dividend as remainder
  if (b_mag == '0) begin
    q_mag = '1;
    r_mag = a_mag;
  end else begin
    q_mag = a_mag / b_mag;
    r_mag = a_mag % b_mag;
  end

  // truncation toward zero, remainder takes the dividend sign
  quot = (a_neg ^ b_neg) ? -q_mag : q_mag;
  rem  = a_neg ? -r_mag : r_mag;
  return {rem, quot};
endfunction

`endif

// ==== bench/imuldiv_tb.sv ====
//------------------------------------------------
// testbench for imuldiv_unit with corner and random requests
// checked against a reference model under back-pressure
//------------------------------------------------

module imuldiv_tb;

  timeunit 1ns;
  timeprecision 100ps;

  import imuldiv_msg_pkg::*;

  `include "imuldiv_ref.svh"

  localparam int W         = imuldiv_w;
  localparam int clk_ns    = 4;
  localparam int n_corner  = 5 * 5 * 4;
  localparam int n_random  = 200;
  localparam int n_total   = n_corner + n_random;
  // resp_rdy stays high until this many responses are checked
  localparam int n_plain   = n_corner + n_random / 2;
  localparam int wd_cycles = 16 + n_total * (W + 8) + 200;

  logic          clk = 1'b0;
  logic          reset;
  logic          req_val;
  logic          req_rdy;
  imuldiv_req_t  req;
  logic          resp_val;
  logic          resp_rdy;
  imuldiv_resp_t resp;

  int            seed = 32'hb201_6936;
  imuldiv_req_t  stim[$];
  imuldiv_req_t  pending[$];
  imuldiv_req_t  done_req;
  logic [63:0]   want;
  logic [63:0]   held;
  int            cycle;
  int            accept_cycle;
  int            n_checked;
  int            stall;
  logic          busy;
  logic          resp_seen;
  logic          stalled;
  logic          prev_val;

  always #(clk_ns / 2) clk = ~clk;

  imuldiv_unit #(.W(W)) u_imuldiv_unit (
    .clk      (clk),
    .reset    (reset),
    .req_val  (req_val),
    .req_rdy  (req_rdy),
    .req      (req),
    .resp_val (resp_val),
    .resp_rdy (resp_rdy),
    .resp     (resp)
  );

  //------------------------------------------------
  // error reporting
  //------------------------------------------------

  task automatic report_mismatch(input string sig, input logic [63:0] got,
                                 input logic [63:0] exp);
    $display("Fail at %0d ns: %s = 0x%0h, expected 0x%0h", $time, sig, got, exp);
    $display("sim failed");
    $fatal(1);
  endtask

  task automatic report_error(input string what);
    $display("Error at %0d ns: %s", $time, what);
    $display("sim failed");
    $fatal(1);
  endtask

  //------------------------------------------------
  // stimulus
  //------------------------------------------------

  // every corner pair in every function and then random requests
  task automatic build_stimulus();
    imuldiv_req_t r;
    logic [W-1:0] ops [5];
    ops[0] = '0;
    ops[1] = W'(1);
    ops[2] = '1;
    ops[3] = {1'b1, {(W-1){1'b0}}};
    ops[4] = {1'b0, {(W-1){1'b1}}};
    for (int f = 0; f < 4; f++) begin
      for (int i = 0; i < 5; i++) begin
        for (int j = 0; j < 5; j++) begin
          r.fn = imuldiv_fn_e'(2'(f));
          r.a  = ops[i];
          r.b  = ops[j];
          stim.push_back(r);
        end
      end
    end
    for (int k = 0; k < n_random; k++) begin
      r.fn = imuldiv_fn_e'(2'($random(seed)));
      r.a  = $random(seed);
      r.b  = $random(seed);
      // short divisors give quotients of more than a bit or two
      if (($random(seed) & 3) == 0) r.b = W'(r.b[7:0]);
      stim.push_back(r);
    end
  endtask

  // hold one request on the bus until the DUT takes it
  task automatic send_request(input imuldiv_req_t r);
    req_val = 1'b1;
    req     = r;
    @(posedge clk);
    while (!req_rdy) @(posedge clk);
    #1;
    req_val = 1'b0;
    req     = '0;
  endtask

  initial begin : main
    reset   = 1'b1;
    req_val = 1'b0;
    req     = '0;
    build_stimulus();
    repeat (16) @(posedge clk);
    #1;
    reset = 1'b0;
    assert (req_rdy === 1'b1) else report_mismatch("req_rdy", 64'(req_rdy), 64'd1);
    assert (resp_val === 1'b0) else report_mismatch("resp_val", 64'(resp_val), 64'd0);
    foreach (stim[i]) send_request(stim[i]);
    wait (n_checked == n_total);
    @(posedge clk);
    #1;
    if (n_checked == n_total && pending.size() == 0) begin
      $display("sim passed");
      $finish;
    end else begin
      report_error("responses left over at the end of the run");
    end
  end

  // back-pressure of 1 to 4 cycles on some fresh responses
  initial begin : drive_resp_rdy
    resp_rdy = 1'b1;
    stall    = 0;
    prev_val = 1'b0;
    wait (reset === 1'b0);
    forever begin
      @(posedge clk);
      #1;
      if (stall == 0 && n_checked >= n_plain && resp_val && !prev_val &&
          ($random(seed) & 1) == 0) begin
        stall = 1 + ($random(seed) & 3);
      end
      prev_val = resp_val;
      if (stall > 0) begin
        resp_rdy = 1'b0;
        stall    = stall - 1;
      end else begin
        resp_rdy = 1'b1;
      end
    end
  end

  //------------------------------------------------
  // response checking
  //------------------------------------------------

  always @(posedge clk) begin
    if (reset) begin
      cycle     = 0;
      busy      = 1'b0;
      resp_seen = 1'b0;
      stalled   = 1'b0;
    end else begin
      cycle = cycle + 1;
      // request side stays closed while an operation is in flight
      if (busy) begin
        assert (!req_rdy) else report_mismatch("req_rdy", 64'(req_rdy), 64'd0);
      end
      // a stalled response holds still until it transfers
      if (stalled) begin
        assert (resp_val) else report_mismatch("resp_val", 64'(resp_val), 64'd1);
        assert (resp.result == held) else report_mismatch("resp.result", resp.result, held);
      end
      assert (!(resp_val && !busy))
        else report_error("response with no request outstanding");
      // first sight of the response comes W+1 edges after the accept
      if (resp_val && !resp_seen) begin
        assert (cycle - accept_cycle == W + 1)
          else report_mismatch("resp_val latency", 64'(cycle - accept_cycle), 64'(W + 1));
        resp_seen = 1'b1;
      end
      if (resp_val && resp_rdy) begin
        done_req = pending.pop_front();
        want     = expected_result(done_req);
        assert (resp.result == want) else begin
          $display("request %s a=0x%h b=0x%h", done_req.fn.name(), done_req.a, done_req.b);
          report_mismatch("resp.result", resp.result, want);
        end
        busy      = 1'b0;
        n_checked = n_checked + 1;
      end
      stalled = resp_val && !resp_rdy;
      held    = resp.result;
      if (req_val && req_rdy) begin
        pending.push_back(req);
        busy         = 1'b1;
        resp_seen    = 1'b0;
        accept_cycle = cycle;
      end
    end
  end

  initial begin : watchdog
    #(wd_cycles * clk_ns);
    report_error($sformatf("timeout after %0d cycles, %0d of %0d responses checked",
                           wd_cycles, n_checked, n_total));
  end

endmodule

// ==== filelist.f ====
+incdir+bench
hw/imuldiv_msg_pkg.sv
hw/imuldiv_ctrl_pkg.sv
hw/int_div_dpath.sv
hw/int_div_ctrl.sv
hw/int_div_iterative.sv
hw/int_mul_iterative.sv
hw/imuldiv_unit.sv
bench/imuldiv_tb.sv

// ==== hw/imuldiv_ctrl_pkg.sv ====
//------------------------------------------------
// divider FSM states and the control/status bundles
// passed between divider control and datapath
//------------------------------------------------

package imuldiv_ctrl_pkg;

  // idle waits for a request, calc iterates, done holds the response
  typedef enum logic [1:0] {
    st_idle = 2'd0,
    st_calc = 2'd1,
    st_done = 2'd2
  } div_state_e;

  //------------------------------------------------
  // control to datapath
  //------------------------------------------------

  typedef struct packed {
    // load the remainder/quotient register
    logic a_en;
    // load the divisor register
    logic b_en;
    // 0 takes the initial dividend, 1 takes the step result
    logic a_sel;
    // reload the iteration counter to W-1
    logic cntr_load;
    // capture quotient and remainder signs
    logic sign_en;
  } div_ctrl_t;

  // datapath to control
  typedef struct packed {
    logic cntr_zero;
  } div_stat_t;

endpackage

// ==== hw/imuldiv_msg_pkg.sv ====
//------------------------------------------------
// request and response messages of the mul/div unit
// imported by the top level and the testbench
//------------------------------------------------

package imuldiv_msg_pkg;

  //------------------------------------------------
  // operand width
  //------------------------------------------------

  // packed structs are fixed in size, so the message width lives here
  // the top level parameter W defaults to this value
  localparam int imuldiv_w = 32;

  //------------------------------------------------
  // function codes
  //------------------------------------------------

  typedef enum logic [1:0] {
    fn_mul  = 2'd0,
    fn_mulu = 2'd1,
    fn_div  = 2'd2,
    fn_divu = 2'd3
  } imuldiv_fn_e;

  // one request, held stable by the sender until the transfer
  typedef struct packed {
    imuldiv_fn_e          fn;
    logic [imuldiv_w-1:0] a;
    logic [imuldiv_w-1:0] b;
  } imuldiv_req_t;

  // multiply gives the full product
  // divide gives {remainder, quotient}
  typedef struct packed {
    logic [2*imuldiv_w-1:0] result;
  } imuldiv_resp_t;

endpackage

// ==== hw/imuldiv_unit.sv ====
//------------------------------------------------
// mul/div unit top, one request in flight at a time
// decodes fn and steers to the multiplier or divider
//------------------------------------------------

module imuldiv_unit #(
  parameter int W = imuldiv_msg_pkg::imuldiv_w
) (
  input  logic                          clk,
  input  logic                          reset,
  input  logic                          req_val,
  output logic                          req_rdy,
  input  imuldiv_msg_pkg::imuldiv_req_t req,
  output logic                          resp_val,
  input  logic                          resp_rdy,
  output imuldiv_msg_pkg::imuldiv_resp_t resp
);

  import imuldiv_msg_pkg::*;

  // message structs are sized by the package constant
  if (W != imuldiv_w) begin : g_width_check
    $error("imuldiv_unit: W must equal the message width");
  end

  //------------------------------------------------
  // function decode
  //------------------------------------------------

  logic is_mul;
  logic is_signed;

  assign is_mul    = (req.fn == fn_mul) || (req.fn == fn_mulu);
  assign is_signed = (req.fn == fn_mul) || (req.fn == fn_div);

  logic           mul_val, mul_rdy, mul_resp_val;
  logic           div_val, div_rdy, div_resp_val;
  logic [2*W-1:0] mul_result;
  logic [2*W-1:0] div_result;

  // a unit only sees val while the other one is idle too,
  // so it never takes a request the top has not accepted
  assign req_rdy = mul_rdy & div_rdy;
  assign mul_val = req_val & is_mul & div_rdy;
  assign div_val = req_val & ~is_mul & mul_rdy;

  int_mul_iterative #(.W(W)) u_mul (
    .clk (clk), .reset (reset),
    .val (mul_val), .rdy (mul_rdy),
    .a (req.a), .b (req.b), .is_signed (is_signed),
    .resp_val (mul_resp_val), .resp_rdy (resp_rdy),
    .result (mul_result)
  );

  int_div_iterative #(.W(W)) u_div (
    .clk (clk), .reset (reset),
    .val (div_val), .rdy (div_rdy),
    .a (req.a), .b (req.b), .is_signed (is_signed),
    .resp_val (div_resp_val), .resp_rdy (resp_rdy),
    .result (div_result)
  );

  // response merge, at most one unit holds a result
  assign resp_val    = mul_resp_val | div_resp_val;
  assign resp.result = div_resp_val ? div_result : mul_result;

  a_one_resp: assert property (@(posedge clk) disable iff (reset)
    !(mul_resp_val && div_resp_val));

endmodule

// ==== hw/int_div_ctrl.sv ====
//------------------------------------------------
// divider control FSM that owns the val/rdy handshake
// and drives the datapath enables and selects
//------------------------------------------------

module int_div_ctrl #(
  parameter int W = 32
) (
  input  logic                        clk,
  input  logic                        reset,
  input  logic                        val,
  output logic                        rdy,
  output logic                        resp_val,
  input  logic                        resp_rdy,
  input  imuldiv_ctrl_pkg::div_stat_t stat,
  output imuldiv_ctrl_pkg::div_ctrl_t ctrl
);

  import imuldiv_ctrl_pkg::*;

  div_state_e state;
  div_state_e state_next;

  //------------------------------------------------
  // state register
  //------------------------------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= st_idle;
    end else begin
      state <= state_next;
    end
  end

  // calc runs until the datapath reports the final step
  always_comb begin
    state_next = state;
    case (state)
      st_idle: if (val) state_next = st_calc;
      st_calc: if (stat.cntr_zero) state_next = st_done;
      st_done: if (resp_rdy) state_next = st_idle;
      default: state_next = st_idle;
    endcase
  end

  //------------------------------------------------
  // outputs decoded from state
  //------------------------------------------------

  always_comb begin
    rdy      = 1'b0;
    resp_val = 1'b0;
    ctrl     = '0;
    case (state)
      st_idle: begin
        // rdy comes from state alone
        rdy = 1'b1;
        // on accept load both operands, counter and signs in one edge
        ctrl.a_en      = val;
        ctrl.b_en      = val;
        ctrl.a_sel     = 1'b0;
        ctrl.cntr_load = val;
        ctrl.sign_en   = val;
      end
      st_calc: begin
        // one shift-subtract step per cycle
        ctrl.a_en  = 1'b1;
        ctrl.a_sel = 1'b1;
      end
      st_done: begin
        // result is held since all enables are low here
        resp_val = 1'b1;
      end
      default: begin
        rdy = 1'b0;
      end
    endcase
  end

  //------------------------------------------------
  // checks
  //------------------------------------------------

  // request and response sides are never open at once
  a_rdy_resp_excl: assert property (@(posedge clk) disable iff (reset)
    !(rdy && resp_val));

  // calc ends on the counter of the datapath and on nothing else
  a_calc_exit: assert property (@(posedge clk) disable iff (reset)
    (state == st_calc) |=> (state == ($past(stat.cntr_zero) ? st_done : st_calc)));

  // an accepted request spends exactly W cycles in calc
  a_calc_len: assert property (@(posedge clk) disable iff (reset)
    (state == st_idle && val) |=> (state == st_calc)[*W] ##1 (state == st_done));

endmodule

// ==== hw/int_div_dpath.sv ====
//------------------------------------------------
// restoring divider datapath, steered by int_div_ctrl
// result is {remainder, quotient} with signs fixed up
//------------------------------------------------

module int_div_dpath #(
  parameter int W = 32
) (
  input  logic                        clk,
  input  logic                        reset,
  input  logic [W-1:0]                a,
  input  logic [W-1:0]                b,
  input  logic                        is_signed,
  input  imuldiv_ctrl_pkg::div_ctrl_t ctrl,
  output imuldiv_ctrl_pkg::div_stat_t stat,
  output logic [2*W-1:0]              result
);

  localparam int cw = $clog2(W);

  //------------------------------------------------
  // operand normalization
  //------------------------------------------------

  logic         a_neg;
  logic         b_neg;
  logic [W-1:0] a_mag;
  logic [W-1:0] b_mag;

  // sign bits only count for the signed functions
  assign a_neg = is_signed & a[W-1];
  assign b_neg = is_signed & b[W-1];

  // most-negative input maps onto 2^(W-1), which still fits unsigned
  assign a_mag = a_neg ? (~a + 1'b1) : a;
  assign b_mag = b_neg ? (~b + 1'b1) : b;

  //------------------------------------------------
  // shift-subtract step
  //------------------------------------------------

  // upper half holds the partial remainder, lower half the quotient
  // extra top bit catches the borrow of the trial subtraction
  logic [2*W:0] rq_reg;
  logic [2*W:0] dv_reg;
  logic [2*W:0] shifted;
  logic [2*W:0] diff;
  logic [2*W:0] step;

  assign shifted = rq_reg << 1;
  assign diff    = shifted - dv_reg;

  // borrow set: restore and shift in a 0, otherwise keep and shift in a 1
  assign step = diff[2*W] ? {shifted[2*W:1], 1'b0} : {diff[2*W:1], 1'b1};

  always_ff @(posedge clk) begin
    if (ctrl.a_en) begin
      rq_reg <= ctrl.a_sel ? step : {{(W+1){1'b0}}, a_mag};
    end
    // divisor sits aligned with the remainder half
    if (ctrl.b_en) begin
      dv_reg <= {1'b0, b_mag, {W{1'b0}}};
    end
  end

  //------------------------------------------------
  // iteration counter
  //------------------------------------------------

  logic [cw-1:0] cntr;

  // counts down once per step, zero marks the last one
  always_ff @(posedge clk) begin
    if (reset) begin
      cntr <= '0;
    end else if (ctrl.cntr_load) begin
      cntr <= cw'(W-1);
    end else if (ctrl.a_en && ctrl.a_sel) begin
      cntr <= cntr - 1'b1;
    end
  end

  assign stat.cntr_zero = (cntr == '0);

  //------------------------------------------------
  // sign fixup
  //------------------------------------------------

  logic         q_neg;
  logic         r_neg;
  logic [W-1:0] quot;
  logic [W-1:0] rem;

  // quotient is negative when the operand signs differ
  // remainder follows the dividend
  always_ff @(posedge clk) begin
    if (ctrl.sign_en) begin
      q_neg <= a_neg ^ b_neg;
      r_neg <= a_neg;
    end
  end

  assign quot   = q_neg ? (~rq_reg[W-1:0] + 1'b1) : rq_reg[W-1:0];
  assign rem    = r_neg ? (~rq_reg[2*W-1:W] + 1'b1) : rq_reg[2*W-1:W];
  assign result = {rem, quot};

endmodule

// ==== hw/int_div_iterative.sv ====
//------------------------------------------------
// iterative divider, joins int_div_ctrl and int_div_dpath
// val/rdy on both sides, W+1 cycles per divide
//------------------------------------------------

module int_div_iterative #(
  parameter int W = 32
) (
  input  logic           clk,
  input  logic           reset,
  input  logic           val,
  output logic           rdy,
  input  logic [W-1:0]   a,
  input  logic [W-1:0]   b,
  input  logic           is_signed,
  output logic           resp_val,
  input  logic           resp_rdy,
  output logic [2*W-1:0] result
);

  import imuldiv_ctrl_pkg::*;

  // enables and selects down, counter status up
  div_ctrl_t ctrl;
  div_stat_t stat;

  int_div_ctrl #(.W(W)) u_ctrl (
    .clk      (clk),
    .reset    (reset),
    .val      (val),
    .rdy      (rdy),
    .resp_val (resp_val),
    .resp_rdy (resp_rdy),
    .stat     (stat),
    .ctrl     (ctrl)
  );

  // is_signed stays on the datapath side
  int_div_dpath #(.W(W)) u_dpath (
    .clk       (clk),
    .reset     (reset),
    .a         (a),
    .b         (b),
    .is_signed (is_signed),
    .ctrl      (ctrl),
    .stat      (stat),
    .result    (result)
  );

endmodule

// ==== hw/int_mul_iterative.sv ====
//------------------------------------------------
// iterative shift-add multiplier, same handshake and
// schedule as the divider, full 2W-bit product
//------------------------------------------------

module int_mul_iterative #(
  parameter int W = 32
) (
  input  logic           clk,
  input  logic           reset,
  input  logic           val,
  output logic           rdy,
  input  logic [W-1:0]   a,
  input  logic [W-1:0]   b,
  input  logic           is_signed,
  output logic           resp_val,
  input  logic           resp_rdy,
  output logic [2*W-1:0] result
);

  localparam int cw = $clog2(W);

  typedef enum logic [1:0] {
    ms_idle = 2'd0,
    ms_calc = 2'd1,
    ms_done = 2'd2
  } mul_state_e;

  mul_state_e    state;
  logic [cw-1:0] cntr;

  // operand magnitudes, multiply is done unsigned
  logic         a_neg;
  logic         b_neg;
  logic [W-1:0] a_mag;
  logic [W-1:0] b_mag;

  assign a_neg = is_signed & a[W-1];
  assign b_neg = is_signed & b[W-1];
  assign a_mag = a_neg ? (~a + 1'b1) : a;
  assign b_mag = b_neg ? (~b + 1'b1) : b;

  //------------------------------------------------
  // FSM and counter
  //------------------------------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= ms_idle;
      cntr  <= '0;
    end else begin
      case (state)
        ms_idle: if (val) begin
          state <= ms_calc;
          cntr  <= cw'(W-1);
        end
        ms_calc: begin
          cntr <= cntr - 1'b1;
          if (cntr == '0) state <= ms_done;
        end
        ms_done: if (resp_rdy) state <= ms_idle;
        default: state <= ms_idle;
      endcase
    end
  end

  assign rdy      = (state == ms_idle);
  assign resp_val = (state == ms_done);

  //------------------------------------------------
  // shift-add datapath
  //------------------------------------------------

  // multiplicand moves left, multiplier moves right
  logic [2*W-1:0] mcand;
  logic [W-1:0]   mplier;
  logic [2*W-1:0] acc;
  logic           neg;

  always_ff @(posedge clk) begin
    if (state == ms_idle && val) begin
      mcand  <= {{W{1'b0}}, a_mag};
      mplier <= b_mag;
      acc    <= '0;
      neg    <= a_neg ^ b_neg;
    end else if (state == ms_calc) begin
      // add the shifted multiplicand for each set multiplier bit
      if (mplier[0]) acc <= acc + mcand;
      mcand  <= mcand << 1;
      mplier <= mplier >> 1;
    end
  end

  assign result = neg ? (~acc + 1'b1) : acc;

  // exactly W add steps between accept and response
  a_mul_iters: assert property (@(posedge clk) disable iff (reset)
    (state == ms_idle && val) |=> (state == ms_calc)[*W] ##1 (state == ms_done));

endmodule
